// File: Bender.yml
package:
  name: sfl_loader

sources:
  - sfl_pkg.sv
  - sfl_shift_reg.sv
  - sfl_instr_decode.sv
  - sfl_dr_bank.sv
  - sfl_asmi_ctrl.sv
  - sfl_loader.sv
  - target: simulation
    files:
      - sfl_loader_chk.sv
      - tb_sfl_loader.sv

// File: sfl_asmi_ctrl.sv
// Flash pin control of the serial flash loader
//   Frame bit counter, cleared after select-DR-scan
//   Frame length per push instruction and frame-active compare
//   Falling-edge chip select, clock enable and serial data
//   Gated flash clock and data1out capture
`timescale 1ns/1ns
`default_nettype none

module sfl_asmi_ctrl
	import sfl_pkg::*;
(
	input  logic       tck,
	input  logic       load_rstatus_inst,
	input  sfl_instr_e instr,
	input  logic       sdr,
	input  logic       sdrs,
	input  logic       push_sout,
	input  logic       data1out,
	output logic       dclkin,
	output logic       scein,
	output logic       sdoin,
	output logic       data1_sampled
);

	logic                     sdrs_reg;
	logic [COUNTER_WIDTH-1:0] bit_count;
	logic [COUNTER_WIDTH-1:0] frame_len;
	logic                     is_push;
	logic                     count_sat;
	logic                     frame_active;
	logic                     dclk_en_reg;

	always_comb begin
		is_push = 1'b1;
		case (instr)
			instr_push_opcode:  frame_len = COUNTER_WIDTH'(OPCODE_REG_WIDTH);
			instr_push_rstatus: frame_len = COUNTER_WIDTH'(RSTATUS_REG_WIDTH);
			instr_push_rsiid:   frame_len = COUNTER_WIDTH'(RSIID_REG_WIDTH);
			instr_push_wbytes,
			instr_push_rbytes:  frame_len = COUNTER_WIDTH'(DATA_REG_WIDTH);
			default: begin
				is_push   = 1'b0;
				frame_len = '0;
			end
		endcase
	end

	// Stop counting once in the top quarter
	assign count_sat    = bit_count[COUNTER_WIDTH-1] & bit_count[COUNTER_WIDTH-2];
	assign frame_active = (bit_count < frame_len);

	// Clear lands during capture-DR, so shifting starts from zero
	always_ff @(posedge tck) begin
		if (load_rstatus_inst) begin
			sdrs_reg  <= 1'b0;
			bit_count <= '0;
		end else begin
			sdrs_reg <= sdrs;
			if (sdrs_reg) begin
				bit_count <= '0;
			end else if (is_push & sdr & ~count_sat) begin
				bit_count <= bit_count + 1'b1;
			end
		end
	end

	// Pins change on the falling edge, the flash samples on the rising one
	always_ff @(negedge tck) begin
		if (load_rstatus_inst) begin
			scein       <= 1'b1;
			dclk_en_reg <= 1'b0;
			sdoin       <= 1'b0;
		end else begin
			scein       <= ~frame_active;
			dclk_en_reg <= frame_active & sdr;
			sdoin       <= push_sout;
		end
	end

	// Enable only changes while tck is low
	assign dclkin = tck & dclk_en_reg;

	// Capture on each flash clock rise
	always_ff @(posedge tck) begin
		if (dclk_en_reg) begin
			data1_sampled <= data1out;
		end
	end

endmodule

`default_nettype wire

// File: sfl_dr_bank.sv
// Data register bank of the serial flash loader
//   Opcode, read-status, silicon-ID and page registers
//   One-bit bypass flop for unknown instructions
//   Serial source toward the flash and TDO select
`timescale 1ns/1ns
`default_nettype none

module sfl_dr_bank
	import sfl_pkg::*;
(
	input  logic       tck,
	input  logic       load_rstatus_inst,
	input  sfl_instr_e instr,
	input  logic       sdr,
	input  logic       tdi,
	input  logic       data1_sampled,
	output logic       push_sout,
	output logic       tdo
);

	logic opcode_en;
	logic rstatus_en;
	logic rsiid_en;
	logic data_en;
	logic opcode_sout;
	logic rstatus_sout;
	logic rsiid_sout;
	logic data_sout;
	logic bypass_out;

	// Load and push of a register share the same shift path
	assign opcode_en  = sdr & (instr inside {instr_load_opcode, instr_push_opcode});
	assign rstatus_en = sdr & (instr inside {instr_load_rstatus, instr_push_rstatus});
	assign rsiid_en   = sdr & (instr inside {instr_load_rsiid, instr_push_rsiid});
	assign data_en    = sdr & (instr inside {instr_load_wbytes, instr_push_wbytes,
	                                         instr_load_rbytes, instr_push_rbytes});

	sfl_shift_reg #(.width(OPCODE_REG_WIDTH)) opcode_reg (
		.tck(tck), .load_rstatus_inst(load_rstatus_inst),
		.shift_en(opcode_en), .shift_in(tdi), .shift_out(opcode_sout)
	);

	sfl_shift_reg #(.width(RSTATUS_REG_WIDTH)) rstatus_reg (
		.tck(tck), .load_rstatus_inst(load_rstatus_inst),
		.shift_en(rstatus_en), .shift_in(tdi), .shift_out(rstatus_sout)
	);

	sfl_shift_reg #(.width(RSIID_REG_WIDTH)) rsiid_reg (
		.tck(tck), .load_rstatus_inst(load_rstatus_inst),
		.shift_en(rsiid_en), .shift_in(tdi), .shift_out(rsiid_sout)
	);

	// Page frame shared by write and read bytes
	sfl_shift_reg #(.width(DATA_REG_WIDTH)) data_reg (
		.tck(tck), .load_rstatus_inst(load_rstatus_inst),
		.shift_en(data_en), .shift_in(tdi), .shift_out(data_sout)
	);

	always_ff @(posedge tck) begin
		if (load_rstatus_inst) begin
			bypass_out <= 1'b0;
		end else begin
			bypass_out <= tdi;
		end
	end

	always_comb begin
		case (instr)
			instr_push_opcode:  push_sout = opcode_sout;
			instr_push_rstatus: push_sout = rstatus_sout;
			instr_push_rsiid:   push_sout = rsiid_sout;
			instr_push_wbytes,
			instr_push_rbytes:  push_sout = data_sout;
			default:            push_sout = 1'b0;
		endcase
	end

	// Read frames return the flash's data line
	always_comb begin
		case (instr)
			instr_push_rsiid,
			instr_push_rbytes,
			instr_push_rstatus: tdo = data1_sampled;
			instr_push_wbytes,
			instr_load_wbytes,
			instr_load_rbytes:  tdo = data_sout;
			instr_push_opcode,
			instr_load_opcode:  tdo = opcode_sout;
			instr_load_rsiid:   tdo = rsiid_sout;
			instr_load_rstatus: tdo = rstatus_sout;
			default:            tdo = bypass_out;
		endcase
	end

endmodule

`default_nettype wire

// File: sfl_instr_decode.sv
// IR decode for the serial flash loader
//   Maps ir_in onto the instruction enum, unknown values to bypass
//   Qualifies the DR scan states with the user-DR select
//   Flash access request and constant IR readback word
`timescale 1ns/1ns
`default_nettype none

module sfl_instr_decode
	import sfl_pkg::*;
(
	input  logic [IR_BITS-1:0] ir_in,
	input  logic               usr1,
	input  logic               jtag_state_sdrs,
	input  logic               jtag_state_sdr,
	input  logic               asmi_access_granted,
	output sfl_instr_e         instr,
	output logic               sdr,
	output logic               sdrs,
	output logic               asmi_access_request,
	output logic [IR_BITS-1:0] ir_out
);

	always_comb begin
		case (ir_in)
			instr_load_opcode,
			instr_push_opcode,
			instr_load_rsiid,
			instr_push_rsiid,
			instr_load_wbytes,
			instr_push_wbytes,
			instr_load_rbytes,
			instr_push_rbytes,
			instr_load_rstatus,
			instr_push_rstatus,
			instr_do_nothing: instr = sfl_instr_e'(ir_in);
			default:          instr = instr_bypass;
		endcase
	end

	// usr1 high selects the hub's user IR, not our DR
	assign sdr  = jtag_state_sdr & ~usr1;
	assign sdrs = jtag_state_sdrs & ~usr1;

	// Held for loads too, so the request does not toggle between load and push
	assign asmi_access_request = (instr != instr_bypass);

	// Grant in the MSB, bit 10 zero, then the version
	assign ir_out = {asmi_access_granted, 1'b0, SFL_VERSION};

endmodule

`default_nettype wire

// File: sfl_loader.f
sfl_pkg.sv
sfl_shift_reg.sv
sfl_instr_decode.sv
sfl_dr_bank.sv
sfl_asmi_ctrl.sv
sfl_loader.sv
sfl_loader_chk.sv
tb_sfl_loader.sv

// File: sfl_loader.sv
// JTAG to serial flash loader, top level
//   Instruction decode
//   Data register bank with bypass
//   Flash pin control
`timescale 1ns/1ns
`default_nettype none

module sfl_loader
	import sfl_pkg::*;
(
	input  logic               tck,
	input  logic               load_rstatus_inst,
	input  logic [IR_BITS-1:0] ir_in,
	input  logic               usr1,
	input  logic               jtag_state_sdrs,
	input  logic               jtag_state_sdr,
	input  logic               tdi,
	input  logic               asmi_access_granted,
	input  logic               data1out,
	output logic [IR_BITS-1:0] ir_out,
	output logic               tdo,
	output logic               asmi_access_request,
	output logic               dclkin,
	output logic               scein,
	output logic               sdoin
);

	sfl_instr_e instr;
	logic       sdr;
	logic       sdrs;
	logic       push_sout;
	logic       data1_sampled;

	sfl_instr_decode u_decode (
		.ir_in               (ir_in),
		.usr1                (usr1),
		.jtag_state_sdrs     (jtag_state_sdrs),
		.jtag_state_sdr      (jtag_state_sdr),
		.asmi_access_granted (asmi_access_granted),
		.instr               (instr),
		.sdr                 (sdr),
		.sdrs                (sdrs),
		.asmi_access_request (asmi_access_request),
		.ir_out              (ir_out)
	);

	sfl_dr_bank u_bank (
		.tck               (tck),
		.load_rstatus_inst (load_rstatus_inst),
		.instr             (instr),
		.sdr               (sdr),
		.tdi               (tdi),
		.data1_sampled     (data1_sampled),
		.push_sout         (push_sout),
		.tdo               (tdo)
	);

	sfl_asmi_ctrl u_asmi (
		.tck               (tck),
		.load_rstatus_inst (load_rstatus_inst),
		.instr             (instr),
		.sdr               (sdr),
		.sdrs              (sdrs),
		.push_sout         (push_sout),
		.data1out          (data1out),
		.dclkin            (dclkin),
		.scein             (scein),
		.sdoin             (sdoin),
		.data1_sampled     (data1_sampled)
	);

endmodule

`default_nettype wire

// File: sfl_loader_chk.sv
// Concurrent assertions on the flash pins of the loader
//   Flash clock only with chip select low
//   Chip select high right after reset
//   No access request for unknown instructions
`timescale 1ns/1ns
`default_nettype none

module sfl_loader_chk
	import sfl_pkg::*;
(
	input logic               tck,
	input logic               load_rstatus_inst,
	input logic [IR_BITS-1:0] ir_in,
	input logic               dclkin,
	input logic               scein,
	input logic               asmi_access_request
);

	logic ir_known;

	assign ir_known = ir_in inside {instr_load_opcode, instr_push_opcode,
	                                instr_load_rsiid, instr_push_rsiid,
	                                instr_load_wbytes, instr_push_wbytes,
	                                instr_load_rbytes, instr_push_rbytes,
	                                instr_load_rstatus, instr_push_rstatus,
	                                instr_do_nothing};

	// Sampled just before the falling edge, while tck is still high
	a_clk_needs_cs: assert property (@(negedge tck) disable iff (load_rstatus_inst)
		dclkin |-> !scein)
		else $error("flash clock pulsed while chip select was high");

	a_cs_after_reset: assert property (@(posedge tck)
		$fell(load_rstatus_inst) |-> scein)
		else $error("chip select not high in the cycle after reset");

	a_no_req_unknown: assert property (@(posedge tck)
		!ir_known |-> !asmi_access_request)
		else $error("access request raised for an unknown instruction");

endmodule

bind sfl_loader sfl_loader_chk u_chk (
	.tck                 (tck),
	.load_rstatus_inst   (load_rstatus_inst),
	.ir_in               (ir_in),
	.dclkin              (dclkin),
	.scein               (scein),
	.asmi_access_request (asmi_access_request)
);

`default_nettype wire

// File: sfl_pkg.sv
// Shared definitions for the JTAG serial flash loader
//   IR width and the version reported on IR readback
//   Frame widths of the four data registers
//   Frame counter width
//   Decoded IR instruction enum
`default_nettype none

package sfl_pkg;

	// JTAG instruction register
	localparam int IR_BITS = 12;

	// Version in the low ten readback bits
	localparam logic [IR_BITS-3:0] SFL_VERSION = 10'd3;

	// 8 command bits
	localparam int OPCODE_REG_WIDTH = 8;

	// 8 command + 8 read bits
	localparam int RSTATUS_REG_WIDTH = 16;

	// 8 command + 24 dummy + 8 read bits
	localparam int RSIID_REG_WIDTH = 40;

	// Page payload bits
	localparam int PAGE_BITS = 64;

	// 8 command + 24 address + page bits
	localparam int DATA_REG_WIDTH = 8 + 24 + PAGE_BITS;

	localparam int COUNTER_WIDTH = 12;

	// Load scans a register back on TDO, push streams it to the flash
	typedef enum logic [IR_BITS-1:0] {
		instr_bypass       = 12'h000,
		instr_load_opcode  = 12'h001,
		instr_push_opcode  = 12'h010,
		instr_load_rsiid   = 12'h002,
		instr_push_rsiid   = 12'h020,
		instr_load_wbytes  = 12'h004,
		instr_push_wbytes  = 12'h040,
		instr_load_rbytes  = 12'h008,
		instr_push_rbytes  = 12'h080,
		instr_load_rstatus = 12'h100,
		instr_push_rstatus = 12'h200,
		instr_do_nothing   = 12'hFFF
	} sfl_instr_e;

endpackage

`default_nettype wire

// File: sfl_shift_reg.sv
// Right-shifting serial register
//   Data enters the MSB, serial output is the LSB
//   Synchronous clear and shift enable
`timescale 1ns/1ns
`default_nettype none

module sfl_shift_reg #(
	parameter int width = 8
) (
	input  logic tck,
	input  logic load_rstatus_inst,
	input  logic shift_en,
	input  logic shift_in,
	output logic shift_out
);

	logic [width-1:0] sr;

	always_ff @(posedge tck) begin
		if (load_rstatus_inst) begin
			sr <= '0;
		end else if (shift_en) begin
			sr <= {shift_in, sr[width-1:1]};
		end
	end

	// A bit shifted in reaches here after width shifts
	assign shift_out = sr[0];

endmodule

`default_nettype wire

// File: tb_sfl_loader.sv
// Directed testbench for the JTAG serial flash loader
//   Clock, reset and a Galois LFSR for random bits
//   Flash clock monitor and a data1out flash model
//   Tests for readback, bypass, load, push and reset
`timescale 1ns/1ns
`default_nettype none

module tb_sfl_loader
	import sfl_pkg::*;
;

	logic               tck;
	logic               load_rstatus_inst;
	logic [IR_BITS-1:0] ir_in;
	logic               usr1;
	logic               jtag_state_sdrs;
	logic               jtag_state_sdr;
	logic               tdi;
	logic               asmi_access_granted;
	logic               data1out;
	logic [IR_BITS-1:0] ir_out;
	logic               tdo;
	logic               asmi_access_request;
	logic               dclkin;
	logic               scein;
	logic               sdoin;

	logic [15:0] lfsr_state;
	logic        tdi_vec [0:191];
	logic        tdo_vec [0:191];
	logic        flash_bits [0:31];
	int          flash_idx;
	int          pulse_cnt;
	int          cs_err;
	logic        sdo_q [$];
	logic        tdo_q [$];
	int          checks;
	int          errors;

	sfl_loader dut0 (
		.tck(tck), .load_rstatus_inst(load_rstatus_inst), .ir_in(ir_in), .usr1(usr1),
		.jtag_state_sdrs(jtag_state_sdrs), .jtag_state_sdr(jtag_state_sdr), .tdi(tdi),
		.asmi_access_granted(asmi_access_granted), .data1out(data1out), .ir_out(ir_out),
		.tdo(tdo), .asmi_access_request(asmi_access_request), .dclkin(dclkin),
		.scein(scein), .sdoin(sdoin)
	);

	always #4 tck = ~tck;

	// Capture what the flash sees on each clock rise
	always @(posedge dclkin) begin
		pulse_cnt++;
		sdo_q.push_back(sdoin);
		if (scein !== 1'b0) begin
			cs_err++;
		end
	end

	// Flash drives its next bit on the falling edge
	always @(negedge dclkin) begin
		tdo_q.push_back(tdo);
		if (flash_idx < 32) begin
			data1out <= flash_bits[flash_idx];
			flash_idx++;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	function automatic logic next_random_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp,
	                         input logic [63:0] got);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		$display("test %-14s %0d errors", name, errors - err_start);
	endtask

	task automatic clear_monitor();
		pulse_cnt = 0;
		cs_err = 0;
		sdo_q.delete();
		tdo_q.delete();
	endtask

	task automatic fill_random(input int n);
		for (int i = 0; i < n; i++) begin
			tdi_vec[i] = next_random_bit();
		end
	endtask

	task automatic fill_word(input logic [15:0] w, input int n);
		for (int i = 0; i < n; i++) begin
			tdi_vec[i] = (i < 16) ? w[i] : 1'b0;
		end
	endtask

	// Select-DR-scan, then one capture cycle
	task automatic select_dr();
		@(posedge tck);
		jtag_state_sdrs <= 1'b1;
		@(posedge tck);
		jtag_state_sdrs <= 1'b0;
	endtask

	// TDO is taken on the falling edge, after i shifts
	task automatic scan(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge tck);
			tdi <= tdi_vec[i];
			jtag_state_sdr <= 1'b1;
			@(negedge tck);
			tdo_vec[i] = tdo;
		end
		@(posedge tck);
		jtag_state_sdr <= 1'b0;
	endtask

	task automatic wait_scein_high(input int limit);
		int n;
		n = 0;
		while (scein !== 1'b1 && n < limit) begin
			@(posedge tck);
			n++;
		end
		if (scein !== 1'b1) begin
			$display("timeout: chip select stayed low after the frame at %0t", $time);
			errors++;
		end
	endtask

	task automatic test_reset_readback();
		int e0;
		e0 = errors;
		@(posedge tck);
		check_val("scein", 1'b1, scein);
		// Mid high phase, so a set clock enable would show on dclkin
		#2;
		check_val("dclkin", 1'b0, dclkin);
		for (int g = 0; g < 2; g++) begin
			@(posedge tck);
			asmi_access_granted <= g[0];
			@(negedge tck);
			check_val("ir_out", {g[0], 1'b0, 10'd3}, ir_out);
		end
		@(posedge tck);
		ir_in <= 12'h000;
		@(negedge tck);
		check_val("asmi_access_request", 1'b0, asmi_access_request);
		@(posedge tck);
		ir_in <= 12'h001;
		@(negedge tck);
		check_val("asmi_access_request", 1'b1, asmi_access_request);
		report_test("reset_readback", e0);
	endtask

	task automatic test_bypass();
		int e0;
		e0 = errors;
		@(posedge tck);
		ir_in <= 12'h000;
		fill_random(32);
		scan(32);
		for (int k = 1; k < 32; k++) begin
			check_val("tdo bypass", tdi_vec[k-1], tdo_vec[k]);
		end
		report_test("bypass", e0);
	endtask

	task automatic load_readback_one(input logic [IR_BITS-1:0] code, input int width);
		@(posedge tck);
		ir_in <= code;
		select_dr();
		fill_random(2 * width);
		scan(2 * width);
		for (int k = 0; k < width; k++) begin
			check_val("tdo load", tdi_vec[k], tdo_vec[width + k]);
		end
	endtask

	task automatic test_load_readback();
		int e0;
		e0 = errors;
		load_readback_one(instr_load_opcode, 8);
		load_readback_one(instr_load_rstatus, 16);
		load_readback_one(instr_load_rsiid, 40);
		load_readback_one(instr_load_wbytes, 96);
		load_readback_one(instr_load_rbytes, 96);
		report_test("load_readback", e0);
	endtask

	task automatic test_opcode_push();
		int         e0;
		logic [7:0] sdo_byte;
		e0 = errors;
		sdo_byte = '0;
		@(posedge tck);
		ir_in <= instr_load_opcode;
		select_dr();
		fill_word(16'h0006, 8);
		scan(8);
		@(posedge tck);
		ir_in <= instr_push_opcode;
		clear_monitor();
		select_dr();
		fill_word(16'h0000, 12);
		scan(12);
		wait_scein_high(20);
		for (int i = 0; i < sdo_q.size() && i < 8; i++) begin
			sdo_byte[i] = sdo_q[i];
		end
		check_val("dclkin pulses", 8, pulse_cnt);
		check_val("scein low at dclkin", 0, cs_err);
		check_val("sdoin", 8'h06, sdo_byte);
		check_val("scein", 1'b1, scein);
		report_test("opcode_push", e0);
	endtask

	task automatic test_status_push();
		int e0;
		e0 = errors;
		@(posedge tck);
		ir_in <= instr_load_rstatus;
		select_dr();
		fill_word(16'h0005, 16);
		scan(16);
		for (int i = 0; i < 32; i++) begin
			flash_bits[i] = next_random_bit();
		end
		flash_idx = 1;
		@(posedge tck);
		data1out <= flash_bits[0];
		ir_in <= instr_push_rstatus;
		clear_monitor();
		select_dr();
		fill_word(16'h0000, 20);
		scan(20);
		wait_scein_high(20);
		check_val("dclkin pulses", 16, pulse_cnt);
		for (int k = 0; k < 16; k++) begin
			check_val("tdo status", flash_bits[k], (k < tdo_q.size()) ? tdo_q[k] : 1'bx);
		end
		report_test("status_push", e0);
	endtask

	task automatic test_reset_mid_scan();
		int e0;
		e0 = errors;
		@(posedge tck);
		ir_in <= instr_load_rsiid;
		select_dr();
		fill_random(40);
		scan(40);
		@(posedge tck);
		load_rstatus_inst <= 1'b1;
		repeat (2) @(posedge tck);
		load_rstatus_inst <= 1'b0;
		select_dr();
		fill_word(16'h0000, 40);
		scan(40);
		for (int k = 0; k < 40; k++) begin
			check_val("tdo rsiid", 1'b0, tdo_vec[k]);
		end
		report_test("reset_mid_scan", e0);
	endtask

	initial begin
		tck = 1'b0;
		load_rstatus_inst = 1'b1;
		ir_in = '0;
		usr1 = 1'b0;
		jtag_state_sdrs = 1'b0;
		jtag_state_sdr = 1'b0;
		tdi = 1'b0;
		asmi_access_granted = 1'b0;
		data1out = 1'b0;
		lfsr_state = 16'd53064;
		flash_idx = 32;
		checks = 0;
		errors = 0;
		repeat (5) @(posedge tck);
		load_rstatus_inst <= 1'b0;
		@(posedge tck);
		clear_monitor();
		test_reset_readback();
		test_bypass();
		test_load_readback();
		test_opcode_push();
		test_status_push();
		test_reset_mid_scan();
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
